//--- logic/serial_pkg.sv
/*
 * Serial side definitions: bit timing of the 8N1 line and program image layout
 */
`default_nettype none

package serial_pkg;

    // line timing, clock cycles per serial bit
    localparam int bit_cycles   = 20;
    localparam int start_cycles = bit_cycles / 2;   // low samples to accept a start bit

    // wide enough for a full bit period count
    typedef logic [$clog2(bit_cycles + 1)-1:0] bit_cnt_t;

    // loaded image, packed little endian into 32-bit words
    localparam int image_bytes = 256;
    localparam int image_words = image_bytes / 4;

    typedef logic [$clog2(image_words)-1:0] word_idx_t;   // 6 bits for 64 words

endpackage

`default_nettype wire

//--- logic/tohost_pkg.sv
/*
 * Host side definitions: Wishbone data width, tohost register map,
 * command encoding and print queue sizing
 */
`default_nettype none

package tohost_pkg;

    typedef logic [31:0] word_t;   // bus data and address

    // register map
    localparam word_t tohost_addr  = 32'h40008000;
    localparam int    stat_off_bit = 0;   // power-off flag in status read
    localparam int    stat_lvl_lsb = 8;   // queue level field, bits 13:8

    // command field of a write to tohost_addr
    localparam int cmd_lsb = 16;

    typedef enum logic [1:0] {
        cmd_none       = 2'd0,
        cmd_print_char = 2'd1,
        cmd_power_off  = 2'd2
    } cmd_t;

    // print queue
    localparam int queue_depth = 32;

    typedef logic [$clog2(queue_depth + 1)-1:0] queue_cnt_t;   // holds 0..32
    typedef logic [$clog2(queue_depth)-1:0]     queue_ptr_t;

endpackage

`default_nettype wire

//--- logic/serial_rx.sv
/*
 * Serial receiver: synchronizes rxd and deserializes 8N1 frames, LSB first
 */
`timescale 1ns/1ps
`default_nettype none

module serial_rx (
    input  wire        CLK,
    input  wire        r_rst,
    input  wire        rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t            state;
    logic                 rxd_m;
    logic                 rxd_s;
    serial_pkg::bit_cnt_t low_cnt;   // consecutive low samples while idle
    serial_pkg::bit_cnt_t bit_cnt;   // cycles into the current bit
    logic [2:0]           bit_idx;
    logic [7:0]           shift;

    // two-flop synchronizer, idles high
    always_ff @(posedge CLK) begin
        if (r_rst) begin
            rxd_m <= 1'b1;
            rxd_s <= 1'b1;
        end else begin
            rxd_m <= rxd;
            rxd_s <= rxd_m;
        end
    end

    always_ff @(posedge CLK) begin
        if (r_rst) begin
            state    <= st_idle;
            low_cnt  <= '0;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                st_idle: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (rxd_s) begin
                        low_cnt <= '0;
                    end else if (low_cnt == serial_pkg::start_cycles - 1) begin
                        low_cnt <= '0;
                        state   <= st_data;   // now near the middle of the start bit
                    end else begin
                        low_cnt <= low_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_cnt == serial_pkg::bit_cycles - 1) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin   // st_stop
                    if (bit_cnt == serial_pkg::bit_cycles - 1) begin
                        bit_cnt  <= '0;
                        rx_valid <= rxd_s;   // drop frames with a low stop bit
                        state    <= st_idle;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // mid-bit sampling, LSB arrives first
    always_ff @(posedge CLK) begin
        if (state == st_data && bit_cnt == serial_pkg::bit_cycles - 1) begin
            shift <= {rxd_s, shift[7:1]};
        end
    end

    assign rx_data = shift;

endmodule

`default_nettype wire

//--- logic/program_loader.sv
/*
 * Program loader: packs received bytes little endian into words and issues
 * one word write per four bytes until the image is complete
 */
`timescale 1ns/1ps
`default_nettype none

module program_loader (
    input  wire                   CLK,
    input  wire                   r_rst,
    input  wire  [7:0]            rx_data,
    input  wire                   rx_valid,
    output serial_pkg::word_idx_t load_addr,
    output tohost_pkg::word_t     load_data,
    output logic                  load_we,
    output logic                  load_done
);

    logic [1:0] lane;   // byte position inside the current word
    logic       take;

    assign take = rx_valid && !load_done;

    always_ff @(posedge CLK) begin
        if (r_rst) begin
            lane      <= '0;
            load_addr <= '0;
            load_we   <= 1'b0;
            load_done <= 1'b0;
        end else begin
            load_we <= take && (lane == 2'd3);
            if (take) begin
                lane <= lane + 1'b1;
            end
            if (load_we) begin
                load_addr <= load_addr + 1'b1;   // index advances after the write
                if (load_addr == serial_pkg::image_words - 1) begin
                    load_done <= 1'b1;           // sticky until reset
                end
            end
        end
    end

    // newest byte enters at the top, first byte ends up least significant
    always_ff @(posedge CLK) begin
        if (take) begin
            load_data <= {rx_data, load_data[31:8]};
        end
    end

endmodule

`default_nettype wire

//--- logic/tohost_regs.sv
/*
 * Wishbone classic slave for the tohost command register and status read.
 * Print commands are stalled while the print queue is full
 */
`timescale 1ns/1ps
`default_nettype none

module tohost_regs (
    input  wire                    CLK,
    input  wire                    r_rst,
    input  wire                    wb_cyc,
    input  wire                    wb_stb,
    input  wire                    wb_we,
    input  wire tohost_pkg::word_t wb_adr,
    input  wire tohost_pkg::word_t wb_dat_w,
    input  wire tohost_pkg::queue_cnt_t level,
    output tohost_pkg::word_t      wb_dat_r,
    output logic                   wb_ack,
    output logic                   push,
    output logic [7:0]             push_char,
    output logic                   power_off
);

    tohost_pkg::cmd_t  cmd;
    tohost_pkg::word_t status;
    logic              req;
    logic              hit;
    logic              do_print;
    logic              do_off;
    logic              full;
    logic              go;

    assign req  = wb_cyc && wb_stb && !wb_ack;   // new request, not the acked one
    assign hit  = (wb_adr == tohost_pkg::tohost_addr);
    assign cmd  = tohost_pkg::cmd_t'(wb_dat_w[tohost_pkg::cmd_lsb +: $bits(tohost_pkg::cmd_t)]);
    assign full = (level == tohost_pkg::queue_depth);

    // command decode, only writes to tohost_addr act
    always_comb begin
        do_print = 1'b0;
        do_off   = 1'b0;
        if (hit && wb_we) begin
            case (cmd)
                tohost_pkg::cmd_print_char: do_print = 1'b1;
                tohost_pkg::cmd_power_off:  do_off   = 1'b1;
                tohost_pkg::cmd_none:       do_print = 1'b0;   // no effect
                default:                    do_off   = 1'b0;
            endcase
        end
    end

    // a print into a full queue waits for room
    assign go = req && !(do_print && full);

    always_comb begin
        status = '0;
        status[tohost_pkg::stat_off_bit] = power_off;
        status[tohost_pkg::stat_lvl_lsb +: $bits(tohost_pkg::queue_cnt_t)] = level;
    end

    always_ff @(posedge CLK) begin
        if (r_rst) begin
            wb_ack    <= 1'b0;
            push      <= 1'b0;
            power_off <= 1'b0;
        end else begin
            wb_ack <= go;
            push   <= go && do_print;   // lands together with the ack
            if (go && do_off) begin
                power_off <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (go) begin
            wb_dat_r  <= (hit && !wb_we) ? status : '0;
            push_char <= wb_dat_w[7:0];
        end
    end

endmodule

`default_nettype wire

//--- logic/print_queue.sv
/*
 * Print queue: circular byte buffer between the tohost register and the
 * serial transmitter
 */
`timescale 1ns/1ps
`default_nettype none

module print_queue (
    input  wire                    CLK,
    input  wire                    r_rst,
    input  wire                    push,
    input  wire  [7:0]             push_char,
    input  wire                    tx_ready,
    output tohost_pkg::queue_cnt_t level,
    output logic [7:0]             tx_data,
    output logic                   tx_start
);

    logic [7:0]             mem [tohost_pkg::queue_depth];
    tohost_pkg::queue_ptr_t head;
    tohost_pkg::queue_ptr_t tail;
    tohost_pkg::queue_cnt_t count;
    logic                   pop;

    assign tail = tohost_pkg::queue_ptr_t'(head + count);   // wraps with the buffer

    // push has priority, and a pending start holds off the next pop
    assign pop = (count != '0) && tx_ready && !push && !tx_start;

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[tail] <= push_char;
        end
        if (pop) begin
            tx_data <= mem[head];
        end
    end

    always_ff @(posedge CLK) begin
        if (r_rst) begin
            head     <= '0;
            count    <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= pop;   // one-cycle start pulse
            if (push) begin
                count <= count + 1'b1;
            end else if (pop) begin
                count <= count - 1'b1;
                head  <= head + 1'b1;
            end
        end
    end

    assign level = count;

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
/*
 * 8N1 serial transmitter: start bit, eight data bits LSB first, stop bit
 */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire       CLK,
    input  wire       r_rst,
    input  wire [7:0] tx_data,
    input  wire       tx_start,
    output logic      txd,
    output logic      tx_ready
);

    logic [8:0]           shreg;       // start bit and data, shifts toward bit 0
    serial_pkg::bit_cnt_t bit_cnt;
    logic [3:0]           bits_left;   // bit periods still to send

    always_ff @(posedge CLK) begin
        if (r_rst) begin
            txd       <= 1'b1;
            tx_ready  <= 1'b1;
            bit_cnt   <= '0;
            bits_left <= '0;
        end else if (tx_ready) begin
            txd     <= 1'b1;   // line idles high
            bit_cnt <= '0;
            if (tx_start) begin
                tx_ready  <= 1'b0;
                txd       <= 1'b0;    // start bit goes out at once
                bits_left <= 4'd10;
            end
        end else if (bit_cnt == serial_pkg::bit_cycles - 1) begin
            bit_cnt   <= '0;
            bits_left <= bits_left - 1'b1;
            if (bits_left == 4'd1) begin
                tx_ready <= 1'b1;   // end of the stop bit
            end else begin
                txd <= shreg[1];    // ones fill in behind the data as the stop bit
            end
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (tx_ready && tx_start) begin
            shreg <= {tx_data, 1'b0};
        end else if (!tx_ready && bit_cnt == serial_pkg::bit_cycles - 1) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule

`default_nettype wire

//--- logic/console_top.sv
/*
 * Serial console peripheral: program loader on the receive side and a
 * Wishbone tohost register feeding a print queue and transmitter
 */
`timescale 1ns/1ps
`default_nettype none

module console_top (
    input  wire                    CLK,
    input  wire                    r_rst,
    input  wire                    rxd,
    input  wire                    wb_cyc,
    input  wire                    wb_stb,
    input  wire                    wb_we,
    input  wire tohost_pkg::word_t wb_adr,
    input  wire tohost_pkg::word_t wb_dat_w,
    output logic                   txd,
    output tohost_pkg::word_t      wb_dat_r,
    output logic                   wb_ack,
    output serial_pkg::word_idx_t  load_addr,
    output tohost_pkg::word_t      load_data,
    output logic                   load_we,
    output logic                   load_done,
    output logic                   power_off
);

    logic [7:0]             rx_data;
    logic                   rx_valid;
    logic                   push;
    logic [7:0]             push_char;
    tohost_pkg::queue_cnt_t level;
    logic [7:0]             tx_data;
    logic                   tx_start;
    logic                   tx_ready;

    // receive path
    serial_rx i_serial_rx (
        .CLK      (CLK),
        .r_rst    (r_rst),
        .rxd      (rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    program_loader i_program_loader (
        .CLK       (CLK),
        .r_rst     (r_rst),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .load_addr (load_addr),
        .load_data (load_data),
        .load_we   (load_we),
        .load_done (load_done)
    );

    // host command and print path
    tohost_regs i_tohost_regs (
        .CLK       (CLK),
        .r_rst     (r_rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .level     (level),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .push      (push),
        .push_char (push_char),
        .power_off (power_off)
    );

    print_queue i_print_queue (
        .CLK       (CLK),
        .r_rst     (r_rst),
        .push      (push),
        .push_char (push_char),
        .tx_ready  (tx_ready),
        .level     (level),
        .tx_data   (tx_data),
        .tx_start  (tx_start)
    );

    uart_tx i_uart_tx (
        .CLK      (CLK),
        .r_rst    (r_rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .txd      (txd),
        .tx_ready (tx_ready)
    );

endmodule

`default_nettype wire

//--- tb/console_assert.sv
/*
 * Bus handshake and loader checks, bound into the console top level
 */
`timescale 1ns/1ps
`default_nettype none

module console_assert (
    input wire CLK,
    input wire r_rst,
    input wire wb_cyc,
    input wire wb_stb,
    input wire wb_ack,
    input wire load_we,
    input wire load_done
);

    ack_in_cycle: assert property (@(posedge CLK) disable iff (r_rst)
        wb_ack |-> (wb_cyc && wb_stb))   // ack only inside an active cycle
        else $error("wb_ack high outside a bus cycle");

    ack_one_cycle: assert property (@(posedge CLK) disable iff (r_rst)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held for two cycles");

    no_load_after_done: assert property (@(posedge CLK) disable iff (r_rst)
        !(load_we && load_done))   // image is closed once done
        else $error("load_we while load_done is set");

endmodule

bind console_top console_assert i_console_assert (
    .CLK       (CLK),
    .r_rst     (r_rst),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .load_we   (load_we),
    .load_done (load_done)
);

`default_nettype wire

//--- tb/console_tb.sv
/*
 * Testbench for the serial console: serial and Wishbone drivers, load and
 * txd monitors, reference model, checks and summary
 */
`timescale 1ns/1ps
`default_nettype none

module console_tb;

    localparam int bc          = serial_pkg::bit_cycles;
    localparam int ack_limit   = 4000;    // a full queue frees one slot per frame
    localparam int drain_limit = 20000;

    logic                  CLK;
    logic                  r_rst;
    logic                  rxd;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    tohost_pkg::word_t     wb_adr;
    tohost_pkg::word_t     wb_dat_w;
    logic                  txd;
    tohost_pkg::word_t     wb_dat_r;
    logic                  wb_ack;
    serial_pkg::word_idx_t load_addr;
    tohost_pkg::word_t     load_data;
    logic                  load_we;
    logic                  load_done;
    logic                  power_off;

    logic [31:0]       lcg_state;
    logic [7:0]        img [serial_pkg::image_bytes];
    logic [7:0]        tx_exp [$];   // bytes written, in print order
    logic [7:0]        tx_got [$];   // bytes decoded from txd
    tohost_pkg::word_t rdata;
    int                load_idx;
    int                tx_seen;
    int                mon_cnt;
    logic              mon_busy;
    logic [7:0]        mon_byte;
    logic [7:0]        cmp_got;
    logic [7:0]        cmp_exp;
    int                errors;
    int                err_mark;
    int                tests;
    int                tests_failed;

    console_top i_dut (
        .CLK       (CLK),
        .r_rst     (r_rst),
        .rxd       (rxd),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .txd       (txd),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .load_addr (load_addr),
        .load_data (load_data),
        .load_we   (load_we),
        .load_done (load_done),
        .power_off (power_off)
    );

    always #20 CLK = ~CLK;   // 40 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_next(lcg_state);
        return lcg_state[23:16];   // upper bits are the better ones
    endfunction

    // expected load word, first received byte least significant
    function automatic tohost_pkg::word_t ref_word(input int idx);
        return {img[4*idx+3], img[4*idx+2], img[4*idx+1], img[4*idx]};
    endfunction

    function automatic tohost_pkg::word_t cmd_word(input tohost_pkg::cmd_t c,
                                                   input logic [7:0] ch);
        tohost_pkg::word_t w;
        w = '0;
        w[tohost_pkg::cmd_lsb +: 2] = c;
        w[7:0] = ch;
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("mismatch %s: got %h, expected %h", name, got, exp);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic abort_run(input string msg);
        $display("timeout: %s", msg);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
    endtask

    // one 8N1 frame on rxd
    task automatic send_byte(input logic [7:0] b);
        @(posedge CLK);
        rxd <= 1'b0;
        repeat (bc) @(posedge CLK);
        for (int k = 0; k < 8; k++) begin
            rxd <= b[k];
            repeat (bc) @(posedge CLK);
        end
        rxd <= 1'b1;   // stop bit
        repeat (bc) @(posedge CLK);
    endtask

    task automatic wb_access(input logic we, input tohost_pkg::word_t adr,
                             input tohost_pkg::word_t dat, output tohost_pkg::word_t rd);
        int n;
        @(posedge CLK);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        n = 0;
        @(negedge CLK);
        while (!wb_ack) begin
            n++;
            if (n > ack_limit) begin
                abort_run("no wb_ack for a bus access");
            end
            @(negedge CLK);
        end
        rd = wb_dat_r;
        @(posedge CLK);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic print_char(input logic [7:0] ch);
        tx_exp.push_back(ch);
        wb_access(1'b1, tohost_pkg::tohost_addr,
                  cmd_word(tohost_pkg::cmd_print_char, ch), rdata);
    endtask

    task automatic read_status();
        wb_access(1'b0, tohost_pkg::tohost_addr, '0, rdata);
    endtask

    task automatic wait_tx_drain();
        int n;
        n = 0;
        while (tx_exp.size() != 0 || mon_busy) begin
            n++;
            if (n > drain_limit) begin
                abort_run("printed bytes did not all appear on txd");
            end
            @(negedge CLK);
        end
    endtask

    // txd must stay idle for the whole window
    task automatic quiet_window(input int cycles);
        logic bad;
        bad = 1'b0;
        for (int k = 0; k < cycles; k++) begin
            @(negedge CLK);
            if (txd !== 1'b1 && !bad) begin
                bad = 1'b1;
                report_error("txd left idle although nothing was printed");
            end
        end
    endtask

    // txd frame decoder, each bit sampled in its middle
    always @(negedge CLK) begin
        if (r_rst) begin
            mon_busy = 1'b0;
            mon_cnt  = 0;
        end else if (!mon_busy) begin
            if (txd == 1'b0) begin
                mon_busy = 1'b1;   // half a cycle into the start bit
                mon_cnt  = 0;
            end
        end else begin
            mon_cnt++;
            if (mon_cnt % bc == bc / 2) begin
                if (mon_cnt / bc == 0) begin
                    if (txd !== 1'b0) begin
                        report_error("start bit on txd was too short");
                        mon_busy = 1'b0;
                    end
                end else if (mon_cnt / bc <= 8) begin
                    mon_byte = {txd, mon_byte[7:1]};   // LSB first
                end else begin
                    if (txd !== 1'b1) begin
                        report_error("stop bit on txd was low");
                    end else begin
                        tx_got.push_back(mon_byte);
                    end
                    mon_busy = 1'b0;
                end
            end
        end
    end

    // decoded bytes against print order
    always @(negedge CLK) begin
        if (tx_got.size() != 0) begin
            cmp_got = tx_got.pop_front();
            tx_seen++;
            if (tx_exp.size() == 0) begin
                report_error($sformatf("unexpected byte %h on txd", cmp_got));
            end else begin
                cmp_exp = tx_exp.pop_front();
                if (cmp_got !== cmp_exp) begin
                    report_mismatch("txd", 32'(cmp_got), 32'(cmp_exp));
                end
            end
        end
    end

    // load writes against the reference image
    always @(negedge CLK) begin
        if (!r_rst && load_we) begin
            if (load_idx >= serial_pkg::image_words) begin
                report_error("load_we after the image was complete");
            end else begin
                if (32'(load_addr) !== 32'(load_idx)) begin
                    report_mismatch("load_addr", 32'(load_addr), 32'(load_idx));
                end
                if (load_data !== ref_word(load_idx)) begin
                    report_mismatch("load_data", load_data, ref_word(load_idx));
                end
            end
            load_idx++;
        end
    end

    initial begin
        int n;
        int lvl;
        int seen_mark;
        CLK          = 1'b0;
        r_rst        = 1'b1;
        rxd          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        lcg_state    = 32'hf24532fd;
        load_idx     = 0;
        tx_seen      = 0;
        errors       = 0;
        tests        = 0;
        tests_failed = 0;
        for (int i = 0; i < serial_pkg::image_bytes; i++) begin
            img[i] = rand_byte();
        end
        repeat (16) @(posedge CLK);
        r_rst <= 1'b0;
        @(negedge CLK);

        err_mark = errors;
        if (txd !== 1'b1) report_mismatch("txd", 32'(txd), 32'h1);
        if (wb_ack !== 1'b0) report_mismatch("wb_ack", 32'(wb_ack), 32'h0);
        if (load_we !== 1'b0) report_mismatch("load_we", 32'(load_we), 32'h0);
        if (load_done !== 1'b0) report_mismatch("load_done", 32'(load_done), 32'h0);
        if (power_off !== 1'b0) report_mismatch("power_off", 32'(power_off), 32'h0);
        finish_test("reset");

        err_mark = errors;
        for (int i = 0; i < serial_pkg::image_bytes; i++) begin
            if (i == serial_pkg::image_bytes - 4 && load_done !== 1'b0) begin
                report_mismatch("load_done", 32'(load_done), 32'h0);   // too early
            end
            send_byte(img[i]);
        end
        n = 0;
        while (load_idx < serial_pkg::image_words) begin
            n++;
            if (n > 4 * bc) begin
                abort_run("load writes stopped before the end of the image");
            end
            @(negedge CLK);
        end
        @(negedge CLK);   // load_done follows the last write
        if (load_done !== 1'b1) report_mismatch("load_done", 32'(load_done), 32'h1);
        repeat (4) send_byte(rand_byte());
        repeat (2 * bc) @(negedge CLK);
        if (load_idx != serial_pkg::image_words) begin
            report_mismatch("load_we count", 32'(load_idx), 32'(serial_pkg::image_words));
        end
        if (load_done !== 1'b1) report_mismatch("load_done", 32'(load_done), 32'h1);
        finish_test("program load");

        err_mark  = errors;
        seen_mark = tx_seen;
        print_char(8'h48);
        print_char(8'h69);
        print_char(8'h21);
        print_char(8'h0d);
        print_char(8'h0a);
        repeat (3) print_char(rand_byte());
        wait_tx_drain();
        if (tx_seen - seen_mark != 8) begin
            report_mismatch("txd frame count", 32'(tx_seen - seen_mark), 32'd8);
        end
        finish_test("printing");

        err_mark  = errors;
        seen_mark = tx_seen;
        for (int i = 0; i < 40; i++) begin
            print_char(rand_byte());
            if (i % 8 == 7) begin
                read_status();
                lvl = int'(rdata[tohost_pkg::stat_lvl_lsb +: 6]);
                if (lvl > tohost_pkg::queue_depth) begin
                    report_error($sformatf("status level %h above queue depth", lvl));
                end else if (i == 39 && lvl != tohost_pkg::queue_depth) begin
                    // the last write waited for a free slot and refilled the queue
                    report_mismatch("status level", 32'(lvl), 32'(tohost_pkg::queue_depth));
                end
            end
        end
        wait_tx_drain();
        if (tx_seen - seen_mark != 40) begin
            report_mismatch("txd frame count", 32'(tx_seen - seen_mark), 32'd40);
        end
        read_status();
        if (rdata !== 32'h0) report_mismatch("wb_dat_r", rdata, 32'h0);   // empty, power on
        finish_test("back-pressure");

        err_mark = errors;
        wb_access(1'b1, tohost_pkg::tohost_addr + 32'd4,
                  cmd_word(tohost_pkg::cmd_print_char, 8'h55), rdata);
        wb_access(1'b1, 32'h0, cmd_word(tohost_pkg::cmd_power_off, 8'h00), rdata);
        wb_access(1'b1, tohost_pkg::tohost_addr ^ 32'h0001_0000,
                  cmd_word(tohost_pkg::cmd_power_off, 8'h00), rdata);
        wb_access(1'b0, tohost_pkg::tohost_addr + 32'd4, '0, rdata);
        if (rdata !== 32'h0) report_mismatch("wb_dat_r", rdata, 32'h0);
        wb_access(1'b0, 32'h0, '0, rdata);
        if (rdata !== 32'h0) report_mismatch("wb_dat_r", rdata, 32'h0);
        quiet_window(12 * bc);
        if (power_off !== 1'b0) report_mismatch("power_off", 32'(power_off), 32'h0);
        finish_test("other addresses");

        err_mark = errors;
        wb_access(1'b1, tohost_pkg::tohost_addr, cmd_word(tohost_pkg::cmd_none, 8'h41), rdata);
        quiet_window(12 * bc);
        if (power_off !== 1'b0) report_mismatch("power_off", 32'(power_off), 32'h0);
        read_status();
        if (rdata !== 32'h0) report_mismatch("wb_dat_r", rdata, 32'h0);
        wb_access(1'b1, tohost_pkg::tohost_addr,
                  cmd_word(tohost_pkg::cmd_power_off, 8'h00), rdata);
        @(negedge CLK);
        if (power_off !== 1'b1) report_mismatch("power_off", 32'(power_off), 32'h1);
        read_status();
        if (rdata !== 32'h1) report_mismatch("wb_dat_r", rdata, 32'h1);
        wb_access(1'b1, tohost_pkg::tohost_addr, cmd_word(tohost_pkg::cmd_none, 8'h42), rdata);
        quiet_window(12 * bc);
        if (power_off !== 1'b1) report_mismatch("power_off", 32'(power_off), 32'h1);
        finish_test("power-off");

        $display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- console.f
logic/serial_pkg.sv
logic/tohost_pkg.sv
logic/serial_rx.sv
logic/program_loader.sv
logic/tohost_regs.sv
logic/print_queue.sv
logic/uart_tx.sv
logic/console_top.sv
tb/console_assert.sv
tb/console_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = console_tb
FILELIST  = console.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
